// File: list.f
source/uce_pkg.sv
source/uce_mem_if.sv
source/uce_req_buffer.sv
source/uce_counters.sv
source/uce_fsm.sv
source/uce_cmd_builder.sv
source/uce_fill_writer.sv
source/uce_top.sv
tb/uce_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f list.f --top-module uce_tb -o uce_sim

# the simulator exits non-zero on failure, so the log decides the result
./obj_dir/uce_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi
exit 0

// File: source/uce_cmd_builder.sv
`default_nettype none

module uce_cmd_builder
  import uce_pkg::*;
#(
  parameter int sets_p = 16
) (
  input  uce_state_e                         state_i,
  input  logic [PADDR_W-1:0]                 req_addr_i,
  input  logic [FILL_W-1:0]                  req_data_i,
  input  req_type_e                          stored_type_i,
  input  logic [PADDR_W-1:0]                 stored_addr_i,
  input  logic [FILL_W-1:0]                  stored_data_i,
  input  logic [$clog2(sets_p)-1:0]          stored_index_i,
  input  logic [PADDR_W-OFFSET_W-$clog2(sets_p)-1:0] stored_tag_i,
  input  logic [BEAT_W-1:0]                  cmd_beat_i,
  uce_mem_if.builder                         mem
);

  always_comb
  begin
    case (state_i)
      e_ready:
      begin
        mem.cmd_type = e_mem_uc_wr;
        mem.cmd_addr = req_addr_i;
        mem.cmd_data = req_data_i;
      end
      e_send_uc:
      begin
        mem.cmd_type = (stored_type_i == e_uc_store) ? e_mem_uc_wr : e_mem_uc_rd;
        mem.cmd_addr = stored_addr_i;
        mem.cmd_data = stored_data_i;
      end
      default:
      begin
        // beats walk the block in ascending order, one fill width apart
        mem.cmd_type = e_mem_rd;
        mem.cmd_addr = {stored_tag_i, stored_index_i, cmd_beat_i, (OFFSET_W - BEAT_W)'(0)};
        mem.cmd_data = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: source/uce_counters.sv
`default_nettype none

module uce_counters
  import uce_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int credits_p = 4
) (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      index_up_i,
  input  logic                      cmd_beat_clear_i,
  input  logic                      resp_beat_up_i,
  input  logic                      resp_taken_i,
  uce_mem_if.counter                mem,
  output logic [$clog2(sets_p)-1:0] index_o,
  output logic                      index_done_o,
  output logic [BEAT_W-1:0]         cmd_beat_o,
  output logic                      cmd_beats_done_o,
  output logic                      resp_last_o,
  output logic                      credits_full_o,
  output logic                      credits_empty_o
);

  localparam int CREDIT_W = $clog2(credits_p + 1);

  logic [BEAT_W:0] cmd_cnt_r;
  logic [BEAT_W-1:0] resp_cnt_r;
  logic [CREDIT_W-1:0] credit_r;
  logic cmd_fire;

  assign cmd_fire = mem.cmd_v & mem.cmd_ready;

  // the set index for clearing wraps so a later clear starts at 0 again
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      index_o <= '0;
    else if (index_up_i)
      index_o <= index_done_o ? '0 : index_o + 1'b1;
  end

  assign index_done_o = (index_o == $clog2(sets_p)'(sets_p - 1));

  always_ff @(posedge clk_i)
  begin
    if (reset_i || cmd_beat_clear_i)
      cmd_cnt_r <= '0;
    else if (cmd_fire && !cmd_beats_done_o)
      cmd_cnt_r <= cmd_cnt_r + 1'b1;
  end

  assign cmd_beat_o = cmd_cnt_r[BEAT_W-1:0];
  assign cmd_beats_done_o = (cmd_cnt_r == (BEAT_W + 1)'(BEATS));

  // fill responses come back in beat order and wrap after the last one
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      resp_cnt_r <= '0;
    else if (resp_beat_up_i)
      resp_cnt_r <= resp_cnt_r + 1'b1;
  end

  assign resp_last_o = (resp_cnt_r == BEAT_W'(BEATS - 1));

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      credit_r <= '0;
    else if (cmd_fire && !resp_taken_i)
      credit_r <= credit_r + 1'b1;
    else if (!cmd_fire && resp_taken_i)
      credit_r <= credit_r - 1'b1;
  end

  assign credits_full_o = (credit_r == CREDIT_W'(credits_p));
  assign credits_empty_o = (credit_r == '0);

endmodule

`default_nettype wire

// File: source/uce_fill_writer.sv
`default_nettype none

module uce_fill_writer
  import uce_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int ways_p = 4
) (
  input  uce_state_e                         state_i,
  input  logic [$clog2(sets_p)-1:0]          index_i,
  input  mem_msg_e                           resp_type_i,
  input  logic [PADDR_W-1:0]                 resp_addr_i,
  input  logic [FILL_W-1:0]                  resp_data_i,
  input  logic [$clog2(ways_p)-1:0]          stored_way_i,
  input  logic                               resp_last_i,
  output tag_op_e                            tag_op_o,
  output logic [$clog2(sets_p)-1:0]          tag_index_o,
  output logic [$clog2(ways_p)-1:0]          tag_way_o,
  output logic [PADDR_W-OFFSET_W-$clog2(sets_p)-1:0] tag_o,
  output data_op_e                           data_op_o,
  output logic [$clog2(sets_p)-1:0]          data_index_o,
  output logic [$clog2(ways_p)-1:0]          data_way_o,
  output logic [BEAT_W-1:0]                  data_beat_o,
  output logic [FILL_W-1:0]                  data_o
);

  localparam int INDEX_W = $clog2(sets_p);
  localparam int TAG_W = PADDR_W - OFFSET_W - INDEX_W;

  logic is_clear;

  assign is_clear = (state_i == e_clear_tags);

  assign tag_op_o = (state_i == e_miss_fill && resp_last_i) ? e_tag_set : e_tag_clear;
  assign tag_index_o = is_clear ? index_i : resp_addr_i[OFFSET_W +: INDEX_W];
  assign tag_way_o = is_clear ? '0 : stored_way_i;
  assign tag_o = is_clear ? '0 : resp_addr_i[PADDR_W-1 -: TAG_W];

  // a beat is one dword wide, so the uncached data needs no replication
  assign data_op_o = (resp_type_i == e_mem_uc_rd) ? e_data_uncached : e_data_fill;
  assign data_index_o = resp_addr_i[OFFSET_W +: INDEX_W];
  assign data_way_o = stored_way_i;
  assign data_beat_o = resp_addr_i[OFFSET_W-1 -: BEAT_W];
  assign data_o = resp_data_i;

endmodule

`default_nettype wire

// File: source/uce_fsm.sv
`default_nettype none

module uce_fsm
  import uce_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       req_v_i,
  input  req_type_e  req_type_i,
  output logic       req_ready_o,
  input  req_type_e  stored_type_i,
  uce_mem_if.fsm     mem,
  input  logic       index_done_i,
  input  logic       cmd_beats_done_i,
  input  logic       resp_last_i,
  input  logic       credits_full_i,
  input  logic       resp_v_i,
  input  mem_msg_e   resp_type_i,
  input  logic       tag_ready_i,
  input  logic       data_ready_i,
  output logic       index_up_o,
  output logic       cmd_beat_clear_o,
  output logic       resp_beat_up_o,
  output logic       resp_taken_o,
  output uce_state_e state_o,
  output logic       tag_v_o,
  output logic       data_v_o,
  output logic       resp_ready_o,
  output logic       busy_o,
  output logic       complete_o
);

  uce_state_e state_r;
  uce_state_e state_n;
  logic store_resp;
  logic load_resp;
  logic load_take;
  logic data_done_r;
  logic tag_done_r;

  assign store_resp = resp_v_i & (resp_type_i inside {e_mem_wr, e_mem_uc_wr});
  assign load_resp = resp_v_i & (resp_type_i inside {e_mem_rd, e_mem_uc_rd});

  always_comb
  begin
    state_n = state_r;
    req_ready_o = 1'b0;
    mem.cmd_v = 1'b0;
    tag_v_o = 1'b0;
    data_v_o = 1'b0;
    index_up_o = 1'b0;
    load_take = 1'b0;
    complete_o = 1'b0;
    case (state_r)
      e_reset:
        state_n = e_clear_tags;
      e_clear_tags:
      begin
        tag_v_o = 1'b1;
        index_up_o = tag_ready_i;
        complete_o = index_done_i & tag_ready_i;
        if (complete_o)
          state_n = e_ready;
      end
      e_ready:
      begin
        // uncached stores leave straight from here and finish on the command
        if (req_type_i == e_uc_store)
        begin
          mem.cmd_v = req_v_i & ~credits_full_i;
          req_ready_o = mem.cmd_v & mem.cmd_ready;
          complete_o = req_ready_o;
        end
        else
        begin
          req_ready_o = 1'b1;
          if (req_v_i)
          begin
            case (req_type_i)
              e_clear:   state_n = e_clear_tags;
              e_uc_load: state_n = e_send_uc;
              default:   state_n = e_miss_fill;
            endcase
          end
        end
      end
      e_send_uc:
      begin
        mem.cmd_v = ~credits_full_i;
        if (mem.cmd_v && mem.cmd_ready)
        begin
          complete_o = (stored_type_i == e_uc_store);
          state_n = complete_o ? e_ready : e_uc_wait;
        end
      end
      e_uc_wait:
      begin
        data_v_o = load_resp;
        load_take = load_resp & data_ready_i;
        complete_o = load_take;
        if (load_take)
          state_n = e_ready;
      end
      e_miss_fill:
      begin
        mem.cmd_v = ~cmd_beats_done_i & ~credits_full_i;
        // the last beat also writes the tag, and the response waits for both
        data_v_o = load_resp & ~data_done_r;
        tag_v_o = load_resp & resp_last_i & ~tag_done_r;
        load_take = load_resp & (data_done_r | data_ready_i)
                    & (~resp_last_i | tag_done_r | tag_ready_i);
        complete_o = load_take & resp_last_i;
        if (complete_o)
          state_n = e_ready;
      end
      default:
        state_n = e_reset;
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_reset;
    else
      state_r <= state_n;
  end

  // remembers a packet that went out while its partner is still stalled
  always_ff @(posedge clk_i)
  begin
    if (reset_i || load_take)
    begin
      data_done_r <= 1'b0;
      tag_done_r <= 1'b0;
    end
    else
    begin
      if (data_v_o && data_ready_i)
        data_done_r <= 1'b1;
      if (state_r == e_miss_fill && tag_v_o && tag_ready_i)
        tag_done_r <= 1'b1;
    end
  end

  assign resp_ready_o = store_resp | load_take;
  assign resp_taken_o = resp_v_i & resp_ready_o;
  assign resp_beat_up_o = load_take & (state_r == e_miss_fill);
  assign cmd_beat_clear_o = req_v_i & req_ready_o;
  assign busy_o = (state_r == e_reset) | (state_r == e_clear_tags);
  assign state_o = state_r;

endmodule

`default_nettype wire

// File: source/uce_mem_if.sv
`default_nettype none

interface uce_mem_if
  import uce_pkg::*;
();

  logic cmd_v;
  logic cmd_ready;
  mem_msg_e cmd_type;
  logic [PADDR_W-1:0] cmd_addr;
  logic [FILL_W-1:0] cmd_data;

  modport builder (output cmd_type, output cmd_addr, output cmd_data);

  modport fsm (output cmd_v, input cmd_ready);

  // credit counting only watches the handshake
  modport counter (input cmd_v, input cmd_ready);

endinterface

`default_nettype wire

// File: source/uce_pkg.sv
`default_nettype none

package uce_pkg;

  localparam int PADDR_W = 32;
  localparam int FILL_W = 64;
  localparam int BLOCK_W = 256;
  localparam int BEATS = BLOCK_W / FILL_W;
  localparam int BEAT_W = $clog2(BEATS);
  localparam int OFFSET_W = $clog2(BLOCK_W / 8);

  typedef enum logic [1:0] {
    e_miss_load,
    e_uc_load,
    e_uc_store,
    e_clear
  } req_type_e;

  typedef enum logic [1:0] {
    e_mem_rd,
    e_mem_wr,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_msg_e;

  typedef enum logic {
    e_data_fill,
    e_data_uncached
  } data_op_e;

  typedef enum logic {
    e_tag_clear,
    e_tag_set
  } tag_op_e;

  typedef enum logic [2:0] {
    e_reset,
    e_clear_tags,
    e_ready,
    e_send_uc,
    e_uc_wait,
    e_miss_fill
  } uce_state_e;

endpackage

`default_nettype wire

// File: source/uce_req_buffer.sv
`default_nettype none

module uce_req_buffer
  import uce_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int ways_p = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               accept_i,
  input  req_type_e                          req_type_i,
  input  logic [PADDR_W-1:0]                 req_addr_i,
  input  logic [FILL_W-1:0]                  req_data_i,
  input  logic [$clog2(ways_p)-1:0]          req_way_i,
  output req_type_e                          type_o,
  output logic [PADDR_W-1:0]                 addr_o,
  output logic [FILL_W-1:0]                  data_o,
  output logic [$clog2(ways_p)-1:0]          way_o,
  output logic [$clog2(sets_p)-1:0]          index_o,
  output logic [PADDR_W-OFFSET_W-$clog2(sets_p)-1:0] tag_o
);

  localparam int INDEX_W = $clog2(sets_p);
  localparam int TAG_W = PADDR_W - OFFSET_W - INDEX_W;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      type_o <= e_miss_load;
    else if (accept_i)
      type_o <= req_type_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (accept_i)
    begin
      addr_o <= req_addr_i;
      data_o <= req_data_i;
      way_o <= req_way_i;
    end
  end

  assign index_o = addr_o[OFFSET_W +: INDEX_W];
  assign tag_o = addr_o[PADDR_W-1 -: TAG_W];

endmodule

`default_nettype wire

// File: source/uce_top.sv
`default_nettype none

module uce_top
  import uce_pkg::*;
#(
  parameter int sets_p = 16,
  parameter int ways_p = 4,
  parameter int credits_p = 4
) (
  input  logic                               clk_i,
  input  logic                               reset_i,
  input  logic                               req_v_i,
  output logic                               req_ready_o,
  input  req_type_e                          req_type_i,
  input  logic [PADDR_W-1:0]                 req_addr_i,
  input  logic [FILL_W-1:0]                  req_data_i,
  input  logic [$clog2(ways_p)-1:0]          req_way_i,
  output logic                               cmd_v_o,
  input  logic                               cmd_ready_i,
  output mem_msg_e                           cmd_type_o,
  output logic [PADDR_W-1:0]                 cmd_addr_o,
  output logic [FILL_W-1:0]                  cmd_data_o,
  input  logic                               resp_v_i,
  output logic                               resp_ready_o,
  input  mem_msg_e                           resp_type_i,
  input  logic [PADDR_W-1:0]                 resp_addr_i,
  input  logic [FILL_W-1:0]                  resp_data_i,
  output logic                               tag_v_o,
  input  logic                               tag_ready_i,
  output tag_op_e                            tag_op_o,
  output logic [$clog2(sets_p)-1:0]          tag_index_o,
  output logic [$clog2(ways_p)-1:0]          tag_way_o,
  output logic [PADDR_W-OFFSET_W-$clog2(sets_p)-1:0] tag_o,
  output logic                               data_v_o,
  input  logic                               data_ready_i,
  output data_op_e                           data_op_o,
  output logic [$clog2(sets_p)-1:0]          data_index_o,
  output logic [$clog2(ways_p)-1:0]          data_way_o,
  output logic [BEAT_W-1:0]                  data_beat_o,
  output logic [FILL_W-1:0]                  data_o,
  output logic                               busy_o,
  output logic                               complete_o,
  output logic                               credits_full_o,
  output logic                               credits_empty_o
);

  localparam int INDEX_W = $clog2(sets_p);
  localparam int WAY_W = $clog2(ways_p);
  localparam int TAG_W = PADDR_W - OFFSET_W - INDEX_W;

  req_type_e stored_type;
  logic [PADDR_W-1:0] stored_addr;
  logic [FILL_W-1:0] stored_data;
  logic [WAY_W-1:0] stored_way;
  logic [INDEX_W-1:0] stored_index;
  logic [TAG_W-1:0] stored_tag;
  logic [INDEX_W-1:0] clear_index;
  logic [BEAT_W-1:0] cmd_beat;
  uce_state_e state;
  logic index_done;
  logic cmd_beats_done;
  logic resp_last;
  logic index_up;
  logic cmd_beat_clear;
  logic resp_beat_up;
  logic resp_taken;

  uce_mem_if mem ();

  assign cmd_v_o = mem.cmd_v;
  assign mem.cmd_ready = cmd_ready_i;
  assign cmd_type_o = mem.cmd_type;
  assign cmd_addr_o = mem.cmd_addr;
  assign cmd_data_o = mem.cmd_data;

  uce_req_buffer #(.sets_p(sets_p), .ways_p(ways_p)) u_req_buffer (
    .clk_i(clk_i), .reset_i(reset_i), .accept_i(req_v_i & req_ready_o),
    .req_type_i(req_type_i), .req_addr_i(req_addr_i),
    .req_data_i(req_data_i), .req_way_i(req_way_i),
    .type_o(stored_type), .addr_o(stored_addr), .data_o(stored_data),
    .way_o(stored_way), .index_o(stored_index), .tag_o(stored_tag)
  );

  uce_counters #(.sets_p(sets_p), .credits_p(credits_p)) u_counters (
    .clk_i(clk_i), .reset_i(reset_i), .index_up_i(index_up),
    .cmd_beat_clear_i(cmd_beat_clear), .resp_beat_up_i(resp_beat_up),
    .resp_taken_i(resp_taken), .mem(mem.counter),
    .index_o(clear_index), .index_done_o(index_done),
    .cmd_beat_o(cmd_beat), .cmd_beats_done_o(cmd_beats_done),
    .resp_last_o(resp_last), .credits_full_o(credits_full_o),
    .credits_empty_o(credits_empty_o)
  );

  uce_fsm u_fsm (
    .clk_i(clk_i), .reset_i(reset_i), .req_v_i(req_v_i), .req_type_i(req_type_i),
    .req_ready_o(req_ready_o), .stored_type_i(stored_type), .mem(mem.fsm),
    .index_done_i(index_done), .cmd_beats_done_i(cmd_beats_done),
    .resp_last_i(resp_last), .credits_full_i(credits_full_o),
    .resp_v_i(resp_v_i), .resp_type_i(resp_type_i),
    .tag_ready_i(tag_ready_i), .data_ready_i(data_ready_i),
    .index_up_o(index_up), .cmd_beat_clear_o(cmd_beat_clear),
    .resp_beat_up_o(resp_beat_up), .resp_taken_o(resp_taken), .state_o(state),
    .tag_v_o(tag_v_o), .data_v_o(data_v_o), .resp_ready_o(resp_ready_o),
    .busy_o(busy_o), .complete_o(complete_o)
  );

  uce_cmd_builder #(.sets_p(sets_p)) u_cmd_builder (
    .state_i(state), .req_addr_i(req_addr_i), .req_data_i(req_data_i),
    .stored_type_i(stored_type), .stored_addr_i(stored_addr),
    .stored_data_i(stored_data), .stored_index_i(stored_index),
    .stored_tag_i(stored_tag), .cmd_beat_i(cmd_beat), .mem(mem.builder)
  );

  uce_fill_writer #(.sets_p(sets_p), .ways_p(ways_p)) u_fill_writer (
    .state_i(state), .index_i(clear_index), .resp_type_i(resp_type_i),
    .resp_addr_i(resp_addr_i), .resp_data_i(resp_data_i),
    .stored_way_i(stored_way), .resp_last_i(resp_last),
    .tag_op_o(tag_op_o), .tag_index_o(tag_index_o), .tag_way_o(tag_way_o),
    .tag_o(tag_o), .data_op_o(data_op_o), .data_index_o(data_index_o),
    .data_way_o(data_way_o), .data_beat_o(data_beat_o), .data_o(data_o)
  );

endmodule

`default_nettype wire

// File: tb/uce_tb.sv
`default_nettype none

module uce_tb
  import uce_pkg::*;
();

  localparam int SETS = 16;
  localparam int WAYS = 4;
  localparam int CREDITS = 3;
  localparam int INDEX_W = $clog2(SETS);
  localparam int WAY_W = $clog2(WAYS);
  localparam int TAG_W = PADDR_W - OFFSET_W - INDEX_W;

  typedef struct packed {
    logic [3:0] op;
    logic [PADDR_W-1:0] addr;
    logic [FILL_W-1:0] data;
    logic [WAY_W-1:0] way;
    logic [INDEX_W-1:0] index;
    logic [TAG_W-1:0] tag;
    logic [FILL_W-1:0] exp_data;
  } step_t;

  typedef struct packed {
    mem_msg_e t;
    logic [PADDR_W-1:0] a;
    logic [FILL_W-1:0] d;
  } cmd_t;

  typedef struct packed {
    tag_op_e op;
    logic [INDEX_W-1:0] index;
    logic [WAY_W-1:0] way;
    logic [TAG_W-1:0] tag;
  } tag_t;

  typedef struct packed {
    data_op_e op;
    logic [INDEX_W-1:0] index;
    logic [WAY_W-1:0] way;
    logic [BEAT_W-1:0] beat;
    logic [FILL_W-1:0] d;
  } data_t;

  logic clk_i;
  logic reset_i;
  logic req_v_i;
  logic req_ready_o;
  req_type_e req_type_i;
  logic [PADDR_W-1:0] req_addr_i;
  logic [FILL_W-1:0] req_data_i;
  logic [WAY_W-1:0] req_way_i;
  logic cmd_v_o;
  logic cmd_ready_i;
  mem_msg_e cmd_type_o;
  logic [PADDR_W-1:0] cmd_addr_o;
  logic [FILL_W-1:0] cmd_data_o;
  logic resp_v_i;
  logic resp_ready_o;
  mem_msg_e resp_type_i;
  logic [PADDR_W-1:0] resp_addr_i;
  logic [FILL_W-1:0] resp_data_i;
  logic tag_v_o;
  logic tag_ready_i;
  tag_op_e tag_op_o;
  logic [INDEX_W-1:0] tag_index_o;
  logic [WAY_W-1:0] tag_way_o;
  logic [TAG_W-1:0] tag_o;
  logic data_v_o;
  logic data_ready_i;
  data_op_e data_op_o;
  logic [INDEX_W-1:0] data_index_o;
  logic [WAY_W-1:0] data_way_o;
  logic [BEAT_W-1:0] data_beat_o;
  logic [FILL_W-1:0] data_o;
  logic busy_o;
  logic complete_o;
  logic credits_full_o;
  logic credits_empty_o;

  step_t steps[$];
  cmd_t exp_cmd_q[$];
  tag_t exp_tag_q[$];
  data_t exp_data_q[$];
  mem_msg_e pend_type_q[$];
  logic [PADDR_W-1:0] pend_addr_q[$];
  int cmd_count = 0;
  int complete_count = 0;
  int cycles = 0;
  int cycle_limit = 1000;
  logic hold_resp = 1'b0;

  uce_top #(.sets_p(SETS), .ways_p(WAYS), .credits_p(CREDITS)) u_dut (.*);

  task automatic stop_with_failure();
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("ERROR: %0t: %s is %b, expected %b", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    if (got != exp)
    begin
      $display("ERROR: %0t: %s is %0d, expected %0d", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_cmd(input mem_msg_e got_t, input logic [PADDR_W-1:0] got_a,
                           input logic [FILL_W-1:0] got_d, input cmd_t e);
    if (got_t !== e.t || got_a !== e.a || got_d !== e.d)
    begin
      $display("ERROR: %0t: command %s %h %h, expected %s %h %h", $time,
               got_t.name(), got_a, got_d, e.t.name(), e.a, e.d);
      stop_with_failure();
    end
  endtask

  task automatic check_tag(input tag_op_e got_op, input logic [INDEX_W-1:0] got_index,
                           input logic [WAY_W-1:0] got_way, input logic [TAG_W-1:0] got_tag,
                           input tag_t e);
    if (got_op !== e.op || got_index !== e.index || got_way !== e.way || got_tag !== e.tag)
    begin
      $display("ERROR: %0t: tag packet %s %h %h %h, expected %s %h %h %h", $time,
               got_op.name(), got_index, got_way, got_tag, e.op.name(), e.index, e.way, e.tag);
      stop_with_failure();
    end
  endtask

  task automatic check_data(input data_op_e got_op, input logic [INDEX_W-1:0] got_index,
                            input logic [WAY_W-1:0] got_way, input logic [BEAT_W-1:0] got_beat,
                            input logic [FILL_W-1:0] got_d, input data_t e);
    if (got_op !== e.op || got_index !== e.index || got_way !== e.way
        || got_beat !== e.beat || got_d !== e.d)
    begin
      $display("ERROR: %0t: data packet %s %h %h %h %h, expected %s %h %h %h %h", $time,
               got_op.name(), got_index, got_way, got_beat, got_d,
               e.op.name(), e.index, e.way, e.beat, e.d);
      stop_with_failure();
    end
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
  begin
    cycles++;
    if (cycles > cycle_limit)
    begin
      $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
      stop_with_failure();
    end
  end

  // random back-pressure on the command and both packet channels
  initial
  begin
    cmd_ready_i = 1'b0;
    tag_ready_i = 1'b0;
    data_ready_i = 1'b0;
    forever
    begin
      @(posedge clk_i);
      #2;
      cmd_ready_i = ($urandom_range(0, 4) != 0);
      tag_ready_i = ($urandom_range(0, 3) != 0);
      data_ready_i = ($urandom_range(0, 3) != 0);
    end
  end

  // the memory model answers in order and returns the beat address twice as read data
  initial
  begin
    logic taken;
    int resp_delay;
    resp_delay = 0;
    resp_v_i = 1'b0;
    resp_type_i = e_mem_rd;
    resp_addr_i = '0;
    resp_data_i = '0;
    forever
    begin
      @(posedge clk_i);
      taken = resp_v_i && resp_ready_o;
      if (!reset_i && cmd_v_o && cmd_ready_i)
      begin
        pend_type_q.push_back(cmd_type_o);
        pend_addr_q.push_back(cmd_addr_o);
      end
      #2;
      if (taken)
      begin
        resp_v_i = 1'b0;
        resp_delay = $urandom_range(0, 3);
      end
      if (!resp_v_i && !hold_resp && pend_type_q.size() > 0)
      begin
        if (resp_delay > 0)
          resp_delay--;
        else
        begin
          resp_type_i = pend_type_q.pop_front();
          resp_addr_i = pend_addr_q.pop_front();
          resp_data_i = {resp_addr_i, resp_addr_i};
          resp_v_i = 1'b1;
        end
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (!reset_i)
    begin
      if (cmd_v_o && cmd_ready_i)
      begin
        if (exp_cmd_q.size() == 0)
        begin
          $display("an unexpected memory command was issued at time %0t", $time);
          stop_with_failure();
        end
        check_cmd(cmd_type_o, cmd_addr_o, cmd_data_o, exp_cmd_q.pop_front());
        cmd_count++;
      end
      if (resp_v_i && (resp_type_i == e_mem_wr || resp_type_i == e_mem_uc_wr))
        check_bit("resp_ready_o for a store response", resp_ready_o, 1'b1);
      if (tag_v_o && tag_ready_i)
      begin
        if (exp_tag_q.size() == 0)
        begin
          $display("an unexpected tag packet was sent at time %0t", $time);
          stop_with_failure();
        end
        if (exp_tag_q[0].op == e_tag_clear)
          check_bit("busy_o", busy_o, 1'b1);
        check_tag(tag_op_o, tag_index_o, tag_way_o, tag_o, exp_tag_q.pop_front());
      end
      if (data_v_o && data_ready_i)
      begin
        if (exp_data_q.size() == 0)
        begin
          $display("an unexpected data packet was sent at time %0t", $time);
          stop_with_failure();
        end
        check_data(data_op_o, data_index_o, data_way_o, data_beat_o, data_o,
                   exp_data_q.pop_front());
      end
      if (complete_o)
        complete_count++;
    end
  end

  task automatic wait_complete(input int target);
    while (complete_count < target)
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic send_request(input step_t s);
    logic accepted;
    accepted = 1'b0;
    @(posedge clk_i);
    #2;
    req_v_i = 1'b1;
    req_type_i = req_type_e'(s.op[1:0]);
    req_addr_i = s.addr;
    req_data_i = s.data;
    req_way_i = s.way;
    while (!accepted)
    begin
      @(posedge clk_i);
      accepted = req_ready_o;
    end
    #2;
    req_v_i = 1'b0;
  endtask

  task automatic expect_clear();
    for (int i = 0; i < SETS; i++)
      exp_tag_q.push_back(tag_t'{e_tag_clear, INDEX_W'(i), '0, '0});
  endtask

  task automatic run_step(input step_t s);
    int done_before;
    int start;
    logic [PADDR_W-1:0] ba;
    done_before = complete_count;
    start = cmd_count;
    case (s.op)
      4'd3:
        expect_clear();
      4'd2:
        exp_cmd_q.push_back(cmd_t'{e_mem_uc_wr, s.addr, s.data});
      4'd1:
      begin
        exp_cmd_q.push_back(cmd_t'{e_mem_uc_rd, s.addr, s.data});
        exp_data_q.push_back(data_t'{e_data_uncached, s.index, s.way,
                                     BEAT_W'((s.addr & 32'h1f) >> 3), s.exp_data});
      end
      default:
      begin
        for (int b = 0; b < BEATS; b++)
        begin
          ba = (s.addr & ~32'h1f) + (b << 3);
          exp_cmd_q.push_back(cmd_t'{e_mem_rd, ba, '0});
          exp_data_q.push_back(data_t'{e_data_fill, s.index, s.way, BEAT_W'(b), {ba, ba}});
        end
        exp_tag_q.push_back(tag_t'{e_tag_set, s.index, s.way, s.tag});
        hold_resp = (s.op == 4'd4);
      end
    endcase
    send_request(s);
    if (s.op == 4'd4)
    begin
      while (cmd_count - start < CREDITS)
      begin
        @(posedge clk_i);
        #1;
      end
      repeat (6) @(posedge clk_i);
      #1;
      check_count("commands issued with responses held", cmd_count - start, CREDITS);
      check_bit("credits_full_o", credits_full_o, 1'b1);
      check_bit("credits_empty_o with responses held", credits_empty_o, 1'b0);
      hold_resp = 1'b0;
    end
    wait_complete(done_before + 1);
    if (s.op == 4'd3)
      check_bit("busy_o after clear", busy_o, 1'b0);
    // every command of the step has had its response taken once the model is idle
    while (pend_type_q.size() > 0 || resp_v_i)
    begin
      @(posedge clk_i);
      #1;
    end
    check_bit("credits_empty_o after all responses", credits_empty_o, 1'b1);
    check_count("completions in the step", complete_count - done_before, 1);
  endtask

  initial
  begin
    int fd;
    int n;
    string line;
    logic [63:0] f[7];
    step_t s;
    void'($urandom(32'h0ff5de61));
    reset_i = 1'b1;
    req_v_i = 1'b0;
    req_type_i = e_miss_load;
    req_addr_i = '0;
    req_data_i = '0;
    req_way_i = '0;
    fd = $fopen("tb/uce_tests.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the test file tb/uce_tests.txt");
      stop_with_failure();
    end
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) == 0)
        break;
      if (line.len() < 2 || line[0] == 8'h23)
        continue;
      n = $sscanf(line, "%h %h %h %h %h %h %h", f[0], f[1], f[2], f[3], f[4], f[5], f[6]);
      if (n == 7)
      begin
        s = '{f[0][3:0], f[1][PADDR_W-1:0], f[2], f[3][WAY_W-1:0],
              f[4][INDEX_W-1:0], f[5][TAG_W-1:0], f[6]};
        steps.push_back(s);
      end
    end
    $fclose(fd);
    // every test line gets a fixed budget, plus one for the clear after reset
    cycle_limit = 200 * (steps.size() + 1);
    expect_clear();
    repeat (2) @(posedge clk_i);
    #1;
    check_bit("req_ready_o in reset", req_ready_o, 1'b0);
    check_bit("cmd_v_o in reset", cmd_v_o, 1'b0);
    check_bit("tag_v_o in reset", tag_v_o, 1'b0);
    check_bit("data_v_o in reset", data_v_o, 1'b0);
    check_bit("complete_o in reset", complete_o, 1'b0);
    check_bit("credits_empty_o in reset", credits_empty_o, 1'b1);
    repeat (2) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    wait_complete(1);
    check_bit("busy_o after reset clear", busy_o, 1'b0);
    foreach (steps[i])
      run_step(steps[i]);
    if (exp_cmd_q.size() == 0 && exp_tag_q.size() == 0 && exp_data_q.size() == 0)
    begin
      $display("STATUS: PASS");
      $finish;
    end
    else
    begin
      $display("expected commands or packets never arrived");
      stop_with_failure();
    end
  end

endmodule

`default_nettype wire

// File: tb/uce_tests.txt
# op addr data way index tag exp_data, all hex
# op: 0 miss, 1 uncached load, 2 uncached store, 3 clear, 4 miss with responses held back
2 00001040 1122334455667788 0 2 000008 1122334455667788
1 80000a08 0000000000000000 0 0 400005 80000a0880000a08
0 12345678 0000000000000000 3 3 091a2b 0000000000000000
0 0000ffe0 0000000000000000 1 f 00007f 0000000000000000
1 deadbee8 0000000000000000 2 7 6f56df deadbee8deadbee8
2 cafe0010 0123456789abcdef 0 0 657f00 0123456789abcdef
3 00000000 0000000000000000 0 0 000000 0000000000000000
4 00400120 0000000000000000 2 9 002000 0000000000000000
0 7fffffc0 0000000000000000 0 e 3fffff 0000000000000000
1 00000000 0000000000000000 0 0 000000 0000000000000000
2 00002468 ffffffff00000000 1 3 000012 ffffffff00000000
4 a5a5a5a0 0000000000000000 1 d 52d2d2 0000000000000000
0 00000020 0000000000000000 3 1 000000 0000000000000000
1 10000018 0000000000000000 1 0 080000 1000001810000018
2 00000008 00000000000000ff 2 0 000000 00000000000000ff
0 00000020 0000000000000000 2 1 000000 0000000000000000
